// ==== sources.f ====
design/uart_pkg.sv
design/uart_baud_gen.sv
design/uart_tx_serializer.sv
design/uart_rx_deserializer.sv
design/uart_cmd_ctrl.sv
design/uart_cmd_top.sv
dv/uart_cmd_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= uart_cmd_tb
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --timing -j 0 --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only --timing --timescale $(TIMESCALE)
PASS_MSG   ?= TEST OK

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulation output is searched for the pass line
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/uart_cmd_tb.sv ====
`default_nettype none

module uart_cmd_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import uart_pkg::*;

  localparam int          CLK_PERIOD = 20;
  localparam int unsigned SEED       = 32'h1214_1a54;
  localparam int          FRAME_WAIT = 4 * FRAME_BITS * CLKS_PER_BIT;
  localparam int          RDY_WAIT   = 3 * FRAME_BITS * CLKS_PER_BIT + 2 * RESP_TIMEOUT;
  // two frames, one extra controller cycle each
  localparam int          WR_LATENCY = 2 * (2 + FRAME_BITS * CLKS_PER_BIT);

  logic              clk;
  logic              rst_n;
  logic [CMD_W-1:0]  cmd_in;
  logic              cmd_vld;
  logic              cmd_rdy;
  logic              tx;
  logic              rx;
  logic [BYTE_W-1:0] read_data;
  logic              read_vld;
  logic              parity_err;
  logic              resp_timeout;

  int n_checks;
  int n_errors;
  int n_tests;
  int err_base;

  // what was seen after the address frame of a read
  int                ans_vld;
  int                ans_perr;
  int                ans_to;
  int                ans_tx_low;
  int                ans_strobe;
  int                ans_rdy;
  logic [BYTE_W-1:0] ans_data;

  uart_cmd_top i_uart_cmd_top (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_byte(input string what, input logic [BYTE_W-1:0] got, exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_cmd(input string what, input logic [CMD_W-1:0] got, exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[ERROR] %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input int got, exp);
    n_checks++;
    if (got != exp) begin
      n_errors++;
      $display("[ERROR] %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    n_errors++;
    $display("gave up at %0d ns, no %s arrived in time", $time, what);
  endtask

  task automatic end_test(input string name);
    n_tests++;
    if (n_errors == err_base) begin
      $display("%-16s passed", name);
    end else begin
      $display("%-16s %0d errors", name, n_errors - err_base);
    end
    err_base = n_errors;
  endtask

  // falling edges until cmd_rdy is seen high
  task automatic wait_rdy(output int cycles);
    cycles = 0;
    while (!cmd_rdy && cycles < RDY_WAIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!cmd_rdy) report_timeout("cmd_rdy");
  endtask

  // returns on the falling edge right after the accepting edge
  task automatic issue_cmd(input logic [CMD_W-1:0] cmd);
    int waited;
    @(negedge clk);
    wait_rdy(waited);
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  // remote device side, samples tx in the middle of each bit
  task automatic receive_frame(output logic [BYTE_W-1:0] data);
    int   waited;
    logic par;
    waited = 0;
    data   = '0;
    while (tx && waited < FRAME_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (tx) begin
      report_timeout("start bit on tx");
    end else begin
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      check_bit("tx start bit", tx, 1'b0);
      for (int i = 0; i < BYTE_W; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        data = {data[BYTE_W-2:0], tx};
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      par = tx;
      // data plus parity must hold an odd count of ones
      check_bit("tx frame parity", ^{data, par}, 1'b1);
      repeat (CLKS_PER_BIT) @(negedge clk);
      check_bit("tx stop bit", tx, 1'b1);
    end
  endtask

  task automatic send_frame(input logic [BYTE_W-1:0] data, input logic bad_parity);
    logic [FRAME_BITS-1:0] bits;
    bits = {1'b0, data, (~^data) ^ bad_parity, 1'b1};
    @(negedge clk);
    for (int i = FRAME_BITS - 1; i >= 0; i--) begin
      rx = bits[i];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
  endtask

  task automatic watch_answer();
    int cyc;
    cyc        = 0;
    ans_vld    = 0;
    ans_perr   = 0;
    ans_to     = 0;
    ans_tx_low = 0;
    ans_strobe = -1;
    ans_rdy    = -1;
    ans_data   = '0;
    while (ans_rdy < 0 && cyc < RDY_WAIT) begin
      @(negedge clk);
      cyc++;
      if (read_vld || parity_err || resp_timeout) ans_strobe = cyc;
      if (read_vld) begin
        ans_vld++;
        ans_data = read_data;
      end
      if (parity_err) ans_perr++;
      if (resp_timeout) ans_to++;
      if (!tx) ans_tx_low++;
      if (cmd_rdy) ans_rdy = cyc;
    end
    if (ans_rdy < 0) report_timeout("cmd_rdy after a read");
  endtask

  // both frames of a write, line idle until cmd_rdy, exact latency
  task automatic expect_write(input logic [CMD_W-1:0] cmd);
    logic [BYTE_W-1:0] addr;
    logic [BYTE_W-1:0] data;
    int                latency;
    int                busy_line;
    busy_line = 0;
    fork
      begin
        receive_frame(addr);
        receive_frame(data);
        check_cmd("write frames", {addr, data}, cmd);
        for (int i = 0; i < RDY_WAIT && !cmd_rdy; i++) begin
          if (!tx) busy_line++;
          @(negedge clk);
        end
      end
      wait_rdy(latency);
    join
    check_count("write latency", latency, WR_LATENCY);
    check_count("tx low cycles after data", busy_line, 0);
  endtask

  task automatic run_read(input logic answer_on, input logic bad_parity,
                          input logic [BYTE_W-1:0] answer);
    logic [CMD_W-1:0]  cmd;
    logic [BYTE_W-1:0] addr;
    cmd = CMD_W'($urandom);
    cmd[CMD_WRITE_BIT] = 1'b0;
    issue_cmd(cmd);
    receive_frame(addr);
    check_byte("read address frame", addr, cmd[CMD_W-1 -: BYTE_W]);
    fork
      if (answer_on) send_frame(answer, bad_parity);
      watch_answer();
    join
  endtask

  task automatic check_read_end(input int vld, input int perr, input int to);
    check_count("read_vld pulses", ans_vld, vld);
    check_count("parity_err pulses", ans_perr, perr);
    check_count("resp_timeout pulses", ans_to, to);
    check_count("cmd_rdy cycle", ans_rdy, ans_strobe + 1);
    check_count("tx low cycles after address", ans_tx_low, 0);
  endtask

  task automatic test_reset();
    int strobes;
    strobes = 0;
    check_bit("cmd_rdy after reset", cmd_rdy, 1'b1);
    check_bit("tx after reset", tx, 1'b1);
    repeat (100) begin
      @(negedge clk);
      if (read_vld || parity_err || resp_timeout) strobes++;
    end
    check_count("strobes after reset", strobes, 0);
    end_test("reset");
  endtask

  task automatic test_write();
    logic [CMD_W-1:0] cmd;
    repeat (3) begin
      cmd = CMD_W'($urandom);
      cmd[CMD_WRITE_BIT] = 1'b1;
      issue_cmd(cmd);
      expect_write(cmd);
    end
    end_test("write");
  endtask

  task automatic test_read_answer();
    logic [BYTE_W-1:0] answer;
    repeat (2) begin
      answer = BYTE_W'($urandom);
      run_read(1'b1, 1'b0, answer);
      check_read_end(1, 0, 0);
      check_byte("read_data", ans_data, answer);
    end
    end_test("read answer");
  endtask

  task automatic test_parity_error();
    run_read(1'b1, 1'b1, BYTE_W'($urandom));
    check_read_end(0, 1, 0);
    end_test("parity error");
  endtask

  task automatic test_timeout();
    run_read(1'b0, 1'b0, '0);
    check_read_end(0, 0, 1);
    // counted from the middle of the address stop bit
    // which ends half a bit later
    check_bit("timeout not early", ans_strobe >= RESP_TIMEOUT + CLKS_PER_BIT / 2, 1'b1);
    check_bit("timeout not late", ans_strobe <= RESP_TIMEOUT + CLKS_PER_BIT, 1'b1);
    end_test("timeout");
  endtask

  task automatic test_backpressure();
    logic [CMD_W-1:0] first;
    logic [CMD_W-1:0] held;
    first = CMD_W'($urandom);
    held  = CMD_W'($urandom);
    first[CMD_WRITE_BIT] = 1'b1;
    held[CMD_WRITE_BIT]  = 1'b1;
    issue_cmd(first);
    cmd_in  = held;
    cmd_vld = 1'b1;
    expect_write(first);
    @(negedge clk);
    check_bit("cmd_rdy after held accept", cmd_rdy, 1'b0);
    cmd_vld = 1'b0;
    expect_write(held);
    end_test("backpressure");
  endtask

  initial begin
    rst_n    = 1'b0;
    cmd_in   = '0;
    cmd_vld  = 1'b0;
    rx       = 1'b1;
    n_checks = 0;
    n_errors = 0;
    n_tests  = 0;
    err_base = 0;
    void'($urandom(SEED));
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_reset();
    test_write();
    test_read_answer();
    test_parity_error();
    test_timeout();
    test_backpressure();
    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : uart_cmd_tb

`default_nettype wire

// ==== design/uart_cmd_top.sv ====
`default_nettype none

module uart_cmd_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [uart_pkg::CMD_W-1:0]  cmd_in,
  input  logic                        cmd_vld,
  output logic                        cmd_rdy,
  output logic                        tx,
  input  logic                        rx,
  output logic [uart_pkg::BYTE_W-1:0] read_data,
  output logic                        read_vld,
  output logic                        parity_err,
  output logic                        resp_timeout
);

  import uart_pkg::*;

  logic              tx_start;
  logic [BYTE_W-1:0] tx_byte;
  logic              tx_done;
  logic              tx_baud_run;
  logic              tx_bit_tick;
  logic              rx_baud_run;
  logic              rx_mid_tick;

  uart_cmd_ctrl i_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_in       (cmd_in),
    .cmd_vld      (cmd_vld),
    .cmd_rdy      (cmd_rdy),
    .tx_start     (tx_start),
    .tx_byte      (tx_byte),
    .tx_done      (tx_done),
    .read_vld     (read_vld),
    .parity_err   (parity_err),
    .resp_timeout (resp_timeout)
  );

  uart_tx_serializer i_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (),
    .tx_done  (tx_done),
    .baud_run (tx_baud_run),
    .bit_tick (tx_bit_tick),
    .tx       (tx)
  );

  // transmit side only needs the bit-end tick
  uart_baud_gen i_tx_baud (
    .clk      (clk),
    .rst_n    (rst_n),
    .baud_run (tx_baud_run),
    .bit_tick (tx_bit_tick),
    .mid_tick ()
  );

  uart_rx_deserializer i_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .baud_run   (rx_baud_run),
    .mid_tick   (rx_mid_tick),
    .read_data  (read_data),
    .read_vld   (read_vld),
    .parity_err (parity_err)
  );

  // receive side samples on the mid tick
  uart_baud_gen i_rx_baud (
    .clk      (clk),
    .rst_n    (rst_n),
    .baud_run (rx_baud_run),
    .bit_tick (),
    .mid_tick (rx_mid_tick)
  );

endmodule : uart_cmd_top

`default_nettype wire

// ==== design/uart_cmd_ctrl.sv ====
`default_nettype none

module uart_cmd_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [uart_pkg::CMD_W-1:0]  cmd_in,
  input  logic                        cmd_vld,
  output logic                        cmd_rdy,
  output logic                        tx_start,
  output logic [uart_pkg::BYTE_W-1:0] tx_byte,
  input  logic                        tx_done,
  input  logic                        read_vld,
  input  logic                        parity_err,
  output logic                        resp_timeout
);

  import uart_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA,
    ST_WAIT
  } state_t;

  state_t               state;
  logic                 is_write;
  logic [BYTE_W-1:0]    data_q;
  logic [TIMEOUT_W-1:0] timer;
  logic                 answered;

  assign cmd_rdy  = (state == ST_IDLE);
  assign answered = read_vld | parity_err;

  // an answer in the last cycle wins over the timeout
  assign resp_timeout = (state == ST_WAIT) && (timer == '0) && !answered;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      is_write <= 1'b0;
      tx_start <= 1'b0;
      timer    <= '0;
    end else begin
      tx_start <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (cmd_vld) begin
            is_write <= cmd_in[CMD_WRITE_BIT];
            tx_start <= 1'b1;
            state    <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          if (tx_done) begin
            if (is_write) begin
              tx_start <= 1'b1;
              state    <= ST_DATA;
            end else begin
              timer <= TIMEOUT_W'(RESP_TIMEOUT - 1);
              state <= ST_WAIT;
            end
          end
        end
        ST_DATA: begin
          if (tx_done) begin
            state <= ST_IDLE;
          end
        end
        ST_WAIT: begin
          if (answered || timer == '0) begin
            state <= ST_IDLE;
          end else begin
            timer <= timer - 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // address byte on accept, data byte after the address frame
  always_ff @(posedge clk) begin
    if (cmd_vld && cmd_rdy) begin
      tx_byte <= cmd_in[CMD_W-1 -: BYTE_W];
      data_q  <= cmd_in[BYTE_W-1:0];
    end else if (state == ST_ADDR && tx_done && is_write) begin
      tx_byte <= data_q;
    end
  end

endmodule : uart_cmd_ctrl

`default_nettype wire

// ==== design/uart_rx_deserializer.sv ====
`default_nettype none

module uart_rx_deserializer (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        rx,
  output logic                        baud_run,
  input  logic                        mid_tick,
  output logic [uart_pkg::BYTE_W-1:0] read_data,
  output logic                        read_vld,
  output logic                        parity_err
);

  import uart_pkg::*;

  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_prev;
  logic                 start_edge;
  logic                 busy;
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic                 par_ok;
  logic                 in_data;

  // two-flop synchronizer, third stage for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign start_edge = rx_prev & ~rx_sync;

  assign baud_run = busy;

  // bit_cnt 0 is the start bit, 1..8 data, 9 parity, 10 stop
  assign in_data = (bit_cnt != '0) && (bit_cnt <= BIT_CNT_W'(BYTE_W));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      bit_cnt    <= '0;
      par_ok     <= 1'b0;
      read_vld   <= 1'b0;
      parity_err <= 1'b0;
    end else begin
      read_vld   <= 1'b0;
      parity_err <= 1'b0;
      if (!busy) begin
        if (start_edge) begin
          busy    <= 1'b1;
          bit_cnt <= '0;
        end
      end else if (mid_tick) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == '0 && rx_sync) begin
          // line back high mid start bit, treat as glitch
          busy <= 1'b0;
        end else if (bit_cnt == BIT_CNT_W'(FRAME_BITS - 2)) begin
          par_ok <= ^{read_data, rx_sync};
        end else if (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1)) begin
          // stop bit value is not checked
          busy       <= 1'b0;
          read_vld   <= par_ok;
          parity_err <= ~par_ok;
        end
      end
    end
  end

  // data arrives msb first
  always_ff @(posedge clk) begin
    if (busy && mid_tick && in_data) begin
      read_data <= {read_data[BYTE_W-2:0], rx_sync};
    end
  end

endmodule : uart_rx_deserializer

`default_nettype wire

// ==== design/uart_tx_serializer.sv ====
`default_nettype none

module uart_tx_serializer (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        tx_start,
  input  logic [uart_pkg::BYTE_W-1:0] tx_byte,
  output logic                        tx_busy,
  output logic                        tx_done,
  output logic                        baud_run,
  input  logic                        bit_tick,
  output logic                        tx
);

  import uart_pkg::*;

  logic [FRAME_BITS-1:0] shreg;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic                  parity;
  logic                  last_bit;

  // odd parity over the data byte
  assign parity = ~^tx_byte;

  assign last_bit = (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1));

  assign baud_run = tx_busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy <= 1'b0;
      tx_done <= 1'b0;
      bit_cnt <= '0;
    end else begin
      tx_done <= 1'b0;
      if (!tx_busy) begin
        if (tx_start) begin
          tx_busy <= 1'b1;
          bit_cnt <= '0;
        end
      end else if (bit_tick) begin
        if (last_bit) begin
          // stop bit period is over
          tx_busy <= 1'b0;
          tx_done <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // msb leaves first: start, data msb..lsb, parity, stop
  // ones shift in behind the frame, so the line idles high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shreg <= '1;
    end else if (tx_start && !tx_busy) begin
      shreg <= {1'b0, tx_byte, parity, 1'b1};
    end else if (tx_busy && bit_tick) begin
      shreg <= {shreg[FRAME_BITS-2:0], 1'b1};
    end
  end

  assign tx = shreg[FRAME_BITS-1];

endmodule : uart_tx_serializer

`default_nettype wire

// ==== design/uart_baud_gen.sv ====
`default_nettype none

module uart_baud_gen (
  input  logic clk,
  input  logic rst_n,
  input  logic baud_run,
  output logic bit_tick,
  output logic mid_tick
);

  import uart_pkg::*;

  logic [BAUD_CNT_W-1:0] cnt;
  logic                  cnt_last;
  logic                  cnt_half;

  assign cnt_last = (cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1));
  assign cnt_half = (cnt == BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1));

  // clears while stopped so each frame starts on a fresh period
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!baud_run) begin
      cnt <= '0;
    end else if (cnt_last) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign bit_tick = baud_run & cnt_last;

  // halfway point, used for sampling the line
  assign mid_tick = baud_run & cnt_half;

endmodule : uart_baud_gen

`default_nettype wire

// ==== design/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

  // bit timing, 115200 baud from a 50 MHz clock
  localparam int CLKS_PER_BIT = 434;

  // wide enough for CLKS_PER_BIT - 1
  localparam int BAUD_CNT_W = 9;

  // command word, bit 15 selects write
  localparam int CMD_W = 16;

  localparam int CMD_WRITE_BIT = 15;

  // payload of one frame
  localparam int BYTE_W = 8;

  // start + 8 data + parity + stop
  localparam int FRAME_BITS = 11;

  localparam int BIT_CNT_W = 4;

  // read answer window, counted from the address frame's tx_done
  // 16 bit periods
  localparam int RESP_TIMEOUT = 16 * CLKS_PER_BIT;

  localparam int TIMEOUT_W = 13;

endpackage : uart_pkg

`default_nettype wire
